// ==== dma_pkg.sv ====
package dma_pkg;

  // Bus widths
  localparam int unsigned AddrW = 32;
  localparam int unsigned DataW = 32;

  typedef logic [AddrW-1:0] addr_t;
  typedef logic [DataW-1:0] data_t;
  // Transfer count, shared by the control register and both engine counters
  typedef logic [10:0]      count_t;
  typedef logic [7:0]       offset_t;
  typedef logic [3:0]       be_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam logic [7:0] RegSrcAddr   = 8'h00;
  localparam logic [7:0] RegDstAddr   = 8'h04;
  localparam logic [7:0] RegControl   = 8'h08;
  // 0x0C is left unmapped
  localparam logic [7:0] RegInterrupt = 8'h10;
  localparam logic [7:0] RegActivate  = 8'h14;
  localparam logic [7:0] RegStatus    = 8'h18;

  // Control register fields
  localparam int unsigned CtrlSrcOffLsb = 24;
  localparam int unsigned CtrlDstOffLsb = 16;
  localparam int unsigned CtrlCountLsb  = 5;
  localparam int unsigned CtrlIrqEnBit  = 4;
  localparam int unsigned CtrlIncSrcBit = 3;
  localparam int unsigned CtrlIncDstBit = 2;
  localparam int unsigned CtrlSizeBit   = 1;
  localparam int unsigned CtrlActBit    = 0;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic {
    WORD = 1'b0,
    BYTE = 1'b1
  } transfer_size_t;

  typedef enum logic [1:0] {
    RCV_IDLE,
    RCV_WAIT_GNT,
    RCV_WAIT_RVALID,
    RCV_WAIT_SPACE
  } receiver_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_WAIT_INPUT,
    TX_WAIT_GNT
  } transmitter_state_t;

  localparam int unsigned FifoDepth = 2;

endpackage

// ==== dma_cfg_if.sv ====
interface dma_cfg_if;

  // Configuration from the register file
  dma_pkg::addr_t          src_addr;
  dma_pkg::addr_t          dst_addr;
  dma_pkg::offset_t        src_offset;
  dma_pkg::offset_t        dst_offset;
  dma_pkg::count_t         num_transfers;
  logic                    inc_src;
  logic                    inc_dst;
  dma_pkg::transfer_size_t size;
  logic                    start;  // one-cycle pulse
  logic                    abort;  // one-cycle pulse

  // Progress reported back by the engines
  dma_pkg::count_t         rcv_count;
  dma_pkg::count_t         tx_count;
  logic                    busy;
  logic                    done;

  modport regs (
    output src_addr, dst_addr, src_offset, dst_offset, num_transfers,
    output inc_src, inc_dst, size, start, abort,
    input  rcv_count, tx_count, busy, done
  );

  modport receiver (
    input  src_addr, src_offset, num_transfers, inc_src, size, start, abort,
    output rcv_count
  );

  modport transmitter (
    input  dst_addr, dst_offset, num_transfers, inc_dst, size, start, abort,
    output tx_count, busy, done
  );

endinterface

// ==== dma_fifo_if.sv ====
interface dma_fifo_if;

  // Write side
  logic           wr_en;
  dma_pkg::data_t wr_data;
  logic           full;
  logic           almost_full;

  // Read side, head is visible on rd_data
  logic           rd_en;
  dma_pkg::data_t rd_data;
  logic           empty;

  modport producer (
    output wr_en, wr_data,
    input  full, almost_full
  );

  modport consumer (
    output rd_en,
    input  rd_data, empty
  );

  modport buffer (
    input  wr_en, wr_data, rd_en,
    output full, almost_full, empty, rd_data
  );

endinterface

// ==== dma_regs.sv ====
module dma_regs (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           reg_req_i,
  input  logic           reg_we_i,
  input  dma_pkg::addr_t reg_addr_i,
  input  dma_pkg::data_t reg_wdata_i,
  output logic           reg_gnt_o,
  output logic           reg_rvalid_o,
  output dma_pkg::data_t reg_rdata_o,
  output logic           reg_err_o,
  output logic           irq_o,
  dma_cfg_if.regs        cfg
);

  // Request captured for decoding in the response cycle
  logic           req_q;
  logic           we_q;
  dma_pkg::addr_t addr_q;
  dma_pkg::data_t wdata_q;
  logic [7:0]     reg_off;

  logic           wr_ok;
  logic           irq_en_q;
  logic           irq_q;
  logic           start_q;
  logic           abort_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
    end else begin
      req_q <= reg_req_i;
      we_q  <= reg_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q  <= reg_addr_i;
    wdata_q <= reg_wdata_i;
  end

  // Always grant, bad accesses are answered with err
  assign reg_gnt_o    = reg_req_i;
  assign reg_rvalid_o = req_q;
  assign reg_off      = {addr_q[7:2], 2'b00};

  // --------------------------------------------------
  // Response decode
  // --------------------------------------------------
  always_comb begin
    reg_rdata_o = '0;
    reg_err_o   = 1'b0;
    if (req_q && we_q) begin
      if (cfg.busy && reg_off != dma_pkg::RegInterrupt) begin
        reg_err_o = 1'b1;
      end else if (!(reg_off inside {dma_pkg::RegSrcAddr, dma_pkg::RegDstAddr,
          dma_pkg::RegControl, dma_pkg::RegInterrupt, dma_pkg::RegActivate})) begin
        reg_err_o = 1'b1;
      end
    end else if (req_q) begin
      case (reg_off)
        dma_pkg::RegSrcAddr: reg_rdata_o = cfg.src_addr;
        dma_pkg::RegDstAddr: reg_rdata_o = cfg.dst_addr;
        dma_pkg::RegControl: begin
          reg_rdata_o = {cfg.src_offset, cfg.dst_offset, cfg.num_transfers, irq_en_q,
                         cfg.inc_src, cfg.inc_dst, cfg.size, cfg.busy};
        end
        dma_pkg::RegStatus: reg_rdata_o = {cfg.rcv_count, cfg.tx_count, 9'b0, cfg.busy};
        default:            reg_err_o   = 1'b1;
      endcase
    end
  end

  assign wr_ok = req_q && we_q && !reg_err_o;

  // --------------------------------------------------
  // Configuration registers and strobes
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cfg.src_addr      <= '0;
      cfg.dst_addr      <= '0;
      cfg.src_offset    <= '0;
      cfg.dst_offset    <= '0;
      cfg.num_transfers <= '0;
      cfg.inc_src       <= 1'b0;
      cfg.inc_dst       <= 1'b0;
      cfg.size          <= dma_pkg::WORD;
      irq_en_q          <= 1'b0;
      start_q           <= 1'b0;
      abort_q           <= 1'b0;
    end else begin
      start_q <= 1'b0;
      abort_q <= 1'b0;
      if (wr_ok) begin
        case (reg_off)
          dma_pkg::RegSrcAddr: cfg.src_addr <= wdata_q;
          dma_pkg::RegDstAddr: cfg.dst_addr <= wdata_q;
          dma_pkg::RegControl: begin
            cfg.src_offset    <= wdata_q[dma_pkg::CtrlSrcOffLsb +: $bits(dma_pkg::offset_t)];
            cfg.dst_offset    <= wdata_q[dma_pkg::CtrlDstOffLsb +: $bits(dma_pkg::offset_t)];
            cfg.num_transfers <= wdata_q[dma_pkg::CtrlCountLsb +: $bits(dma_pkg::count_t)];
            irq_en_q          <= wdata_q[dma_pkg::CtrlIrqEnBit];
            cfg.inc_src       <= wdata_q[dma_pkg::CtrlIncSrcBit];
            cfg.inc_dst       <= wdata_q[dma_pkg::CtrlIncDstBit];
            cfg.size          <= wdata_q[dma_pkg::CtrlSizeBit] ? dma_pkg::BYTE : dma_pkg::WORD;
            start_q           <= wdata_q[dma_pkg::CtrlActBit];
          end
          dma_pkg::RegInterrupt: abort_q <= 1'b1;
          dma_pkg::RegActivate:  start_q <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  assign cfg.start = start_q;
  assign cfg.abort = abort_q;

  // Interrupt flag, set on completion and dropped by the next access
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      irq_q <= 1'b0;
    end else if (cfg.done && irq_en_q) begin
      irq_q <= 1'b1;
    end else if (req_q) begin
      irq_q <= 1'b0;
    end
  end

  assign irq_o = irq_q;

  a_start_abort_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cfg.start && cfg.abort));

endmodule

// ==== dma_receiver.sv ====
module dma_receiver (
  input  logic           clk_i,
  input  logic           rst_ni,
  dma_cfg_if.receiver    cfg,
  dma_fifo_if.producer   fifo,
  output logic           rd_req_o,
  output dma_pkg::addr_t rd_addr_o,
  input  logic           rd_gnt_i,
  input  logic           rd_rvalid_i,
  input  dma_pkg::data_t rd_rdata_i
);

  dma_pkg::receiver_state_t state_d, state_q;
  dma_pkg::addr_t           ptr_d, ptr_q;
  dma_pkg::count_t          count_d, count_q;
  dma_pkg::addr_t           step;

  assign step = (cfg.size == dma_pkg::BYTE) ? dma_pkg::addr_t'(1) : dma_pkg::addr_t'(4);

  // Request is held for as long as the FSM waits for the grant
  assign rd_req_o      = (state_q == dma_pkg::RCV_WAIT_GNT);
  assign rd_addr_o     = ptr_q;
  assign cfg.rcv_count = count_q;

  // Read data goes straight into the FIFO
  assign fifo.wr_en   = (state_q == dma_pkg::RCV_WAIT_RVALID) && rd_rvalid_i && !cfg.abort;
  assign fifo.wr_data = (cfg.size == dma_pkg::BYTE) ?
                        dma_pkg::data_t'(rd_rdata_i[{ptr_q[1:0], 3'b000} +: 8]) : rd_rdata_i;

  // --------------------------------------------------
  // Receiver FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    ptr_d   = ptr_q;
    count_d = count_q;
    case (state_q)
      dma_pkg::RCV_IDLE: begin
        if (cfg.start) begin
          ptr_d   = cfg.src_addr + dma_pkg::addr_t'(cfg.src_offset);
          count_d = dma_pkg::count_t'(1);
          state_d = dma_pkg::RCV_WAIT_GNT;
        end
      end
      dma_pkg::RCV_WAIT_GNT: begin
        if (rd_gnt_i) begin
          state_d = dma_pkg::RCV_WAIT_RVALID;
        end
      end
      dma_pkg::RCV_WAIT_RVALID: begin
        if (rd_rvalid_i) begin
          count_d = count_q + 1'b1;
          if (cfg.inc_src) begin
            ptr_d = ptr_q + step;
          end
          if (count_q == cfg.num_transfers) begin
            state_d = dma_pkg::RCV_IDLE;
          end else if (fifo.almost_full) begin
            // This push fills the last free entry
            state_d = dma_pkg::RCV_WAIT_SPACE;
          end else begin
            state_d = dma_pkg::RCV_WAIT_GNT;
          end
        end
      end
      dma_pkg::RCV_WAIT_SPACE: begin
        if (!fifo.full) begin
          state_d = dma_pkg::RCV_WAIT_GNT;
        end
      end
      default: state_d = dma_pkg::RCV_IDLE;
    endcase
    // Abort wins over every transition
    if (cfg.abort) begin
      state_d = dma_pkg::RCV_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= dma_pkg::RCV_IDLE;
      ptr_q   <= '0;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      ptr_q   <= ptr_d;
      count_q <= count_d;
    end
  end

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_o && !rd_gnt_i && !cfg.abort |=> rd_req_o && $stable(rd_addr_o));

endmodule

// ==== dma_fifo.sv ====
module dma_fifo #(
  parameter int unsigned Depth = dma_pkg::FifoDepth
) (
  input logic        clk_i,
  input logic        rst_ni,
  dma_fifo_if.buffer fifo
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  dma_pkg::data_t  mem [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;

  // Wrap at the last entry
  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (fifo.wr_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (fifo.rd_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (fifo.wr_en && !fifo.rd_en) begin
        count_q <= count_q + 1'b1;
      end else if (fifo.rd_en && !fifo.wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo.wr_en) begin
      mem[wr_ptr_q] <= fifo.wr_data;
    end
  end

  assign fifo.rd_data     = mem[rd_ptr_q];
  assign fifo.empty       = (count_q == '0);
  assign fifo.full        = (count_q == CntW'(Depth));
  assign fifo.almost_full = (count_q == CntW'(Depth - 1));

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo.wr_en |-> !fifo.full);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo.rd_en |-> !fifo.empty);

endmodule

// ==== dma_transmitter.sv ====
module dma_transmitter (
  input  logic           clk_i,
  input  logic           rst_ni,
  dma_cfg_if.transmitter cfg,
  dma_fifo_if.consumer   fifo,
  output logic           wr_req_o,
  output dma_pkg::addr_t wr_addr_o,
  output dma_pkg::be_t   wr_be_o,
  output dma_pkg::data_t wr_wdata_o,
  input  logic           wr_gnt_i
);

  dma_pkg::transmitter_state_t state_d, state_q;
  dma_pkg::addr_t              ptr_d, ptr_q;
  dma_pkg::addr_t              ptr_next;
  dma_pkg::addr_t              load_ptr;
  dma_pkg::addr_t              step;
  dma_pkg::count_t             count_d, count_q;
  dma_pkg::be_t                be_d, be_q;
  dma_pkg::data_t              wdata_d, wdata_q;
  logic                        done_d, done_q;
  logic                        pop;

  // Single lane enable for a byte address
  function automatic dma_pkg::be_t lane_be(dma_pkg::addr_t addr);
    return dma_pkg::be_t'(1) << addr[1:0];
  endfunction

  assign step     = (cfg.size == dma_pkg::BYTE) ? dma_pkg::addr_t'(1) : dma_pkg::addr_t'(4);
  assign ptr_next = cfg.inc_dst ? ptr_q + step : ptr_q;

  assign wr_req_o     = (state_q == dma_pkg::TX_WAIT_GNT);
  assign wr_addr_o    = ptr_q;
  assign wr_be_o      = be_q;
  assign wr_wdata_o   = wdata_q;
  assign fifo.rd_en   = pop;
  assign cfg.tx_count = count_q;
  assign cfg.busy     = (state_q != dma_pkg::TX_IDLE);
  assign cfg.done     = done_q;

  // --------------------------------------------------
  // Transmitter FSM
  // --------------------------------------------------
  always_comb begin
    state_d  = state_q;
    ptr_d    = ptr_q;
    count_d  = count_q;
    be_d     = be_q;
    wdata_d  = wdata_q;
    done_d   = 1'b0;
    pop      = 1'b0;
    load_ptr = ptr_q;
    case (state_q)
      dma_pkg::TX_IDLE: begin
        if (cfg.start) begin
          ptr_d   = cfg.dst_addr + dma_pkg::addr_t'(cfg.dst_offset);
          count_d = dma_pkg::count_t'(1);
          state_d = dma_pkg::TX_WAIT_INPUT;
        end
      end
      dma_pkg::TX_WAIT_INPUT: begin
        if (!fifo.empty) begin
          pop     = 1'b1;
          state_d = dma_pkg::TX_WAIT_GNT;
        end
      end
      dma_pkg::TX_WAIT_GNT: begin
        if (wr_gnt_i) begin
          count_d  = count_q + 1'b1;
          ptr_d    = ptr_next;
          load_ptr = ptr_next;
          if (count_q == cfg.num_transfers) begin
            state_d = dma_pkg::TX_IDLE;
            done_d  = 1'b1;
          end else if (!fifo.empty) begin
            // Back-to-back write, the request stays up
            pop = 1'b1;
          end else begin
            state_d = dma_pkg::TX_WAIT_INPUT;
          end
        end
      end
      default: state_d = dma_pkg::TX_IDLE;
    endcase
    if (cfg.abort) begin
      state_d = dma_pkg::TX_IDLE;
      done_d  = 1'b0;
      pop     = 1'b0;
    end
    // Popped entry becomes the next write beat
    if (pop && cfg.size == dma_pkg::BYTE) begin
      wdata_d = {4{fifo.rd_data[7:0]}};
      be_d    = lane_be(load_ptr);
    end else if (pop) begin
      wdata_d = fifo.rd_data;
      be_d    = '1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= dma_pkg::TX_IDLE;
      ptr_q   <= '0;
      count_q <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      ptr_q   <= ptr_d;
      count_q <= count_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    be_q    <= be_d;
    wdata_q <= wdata_d;
  end

endmodule

// ==== dma.sv ====
module dma (
  input  logic           clk_i,
  input  logic           rst_ni,

  // Register port
  input  logic           reg_req_i,
  input  logic           reg_we_i,
  input  dma_pkg::addr_t reg_addr_i,
  input  dma_pkg::data_t reg_wdata_i,
  output logic           reg_gnt_o,
  output logic           reg_rvalid_o,
  output dma_pkg::data_t reg_rdata_o,
  output logic           reg_err_o,

  // Read manager port
  output logic           rd_req_o,
  output dma_pkg::addr_t rd_addr_o,
  input  logic           rd_gnt_i,
  input  logic           rd_rvalid_i,
  input  dma_pkg::data_t rd_rdata_i,

  // Write manager port
  output logic           wr_req_o,
  output dma_pkg::addr_t wr_addr_o,
  output dma_pkg::be_t   wr_be_o,
  output dma_pkg::data_t wr_wdata_o,
  input  logic           wr_gnt_i,

  output logic           irq_o
);

  dma_cfg_if  cfg ();
  dma_fifo_if fifo_bus ();

  dma_regs i_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .reg_req_i    (reg_req_i),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_gnt_o    (reg_gnt_o),
    .reg_rvalid_o (reg_rvalid_o),
    .reg_rdata_o  (reg_rdata_o),
    .reg_err_o    (reg_err_o),
    .irq_o        (irq_o),
    .cfg          (cfg.regs)
  );

  dma_receiver i_receiver (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg         (cfg.receiver),
    .fifo        (fifo_bus.producer),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_gnt_i    (rd_gnt_i),
    .rd_rvalid_i (rd_rvalid_i),
    .rd_rdata_i  (rd_rdata_i)
  );

  // Two entries let a read overlap the write that drains the previous word
  dma_fifo #(
    .Depth (dma_pkg::FifoDepth)
  ) i_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .fifo   (fifo_bus.buffer)
  );

  dma_transmitter i_transmitter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg        (cfg.transmitter),
    .fifo       (fifo_bus.consumer),
    .wr_req_o   (wr_req_o),
    .wr_addr_o  (wr_addr_o),
    .wr_be_o    (wr_be_o),
    .wr_wdata_o (wr_wdata_o),
    .wr_gnt_i   (wr_gnt_i)
  );

endmodule

// ==== tb_dma_mem.sv ====
module tb_dma_mem (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           slow_i,
  input  logic           rd_req_i,
  input  dma_pkg::addr_t rd_addr_i,
  output logic           rd_gnt_o,
  output logic           rd_rvalid_o,
  output dma_pkg::data_t rd_rdata_o,
  input  logic           wr_req_i,
  input  dma_pkg::addr_t wr_addr_i,
  input  dma_pkg::be_t   wr_be_i,
  input  dma_pkg::data_t wr_wdata_i,
  output logic           wr_gnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // 256 words, indexed by address bits 9:2
  dma_pkg::data_t mem [256];
  logic [15:0]    lfsr;
  logic           rd_armed, wr_armed;
  logic [4:0]     rd_wait, wr_wait;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per delay bit, slow mode stretches every grant
  task automatic draw_delay(output logic [4:0] delay);
    logic [1:0] bits;
    lfsr = lfsr_next(lfsr);
    bits[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    bits[1] = lfsr[0];
    delay = {3'b000, bits} + (slow_i ? 5'd12 : 5'd0);
  endtask

  initial begin
    rd_gnt_o    = 1'b0;
    rd_rvalid_o = 1'b0;
    rd_rdata_o  = '0;
    wr_gnt_o    = 1'b0;
  end

  always @(posedge clk_i) begin
    logic [4:0] delay;
    if (!rst_ni) begin
      lfsr = 16'd16;
      rd_gnt_o    <= 1'b0;
      rd_rvalid_o <= 1'b0;
      wr_gnt_o    <= 1'b0;
      rd_armed    <= 1'b0;
      wr_armed    <= 1'b0;
    end else begin
      rd_gnt_o    <= 1'b0;
      rd_rvalid_o <= 1'b0;
      wr_gnt_o    <= 1'b0;

      // Read port, data returns one cycle after the grant
      if (rd_gnt_o && rd_req_i) begin
        rd_rvalid_o <= 1'b1;
        rd_rdata_o  <= mem[rd_addr_i[9:2]];
      end else if (!rd_req_i) begin
        rd_armed <= 1'b0;
      end else if (!rd_armed) begin
        draw_delay(delay);
        rd_wait  <= delay;
        rd_armed <= 1'b1;
      end else if (rd_wait == '0) begin
        rd_gnt_o <= 1'b1;
        rd_armed <= 1'b0;
      end else begin
        rd_wait <= rd_wait - 1'b1;
      end

      // Write port, byte lanes applied on the grant cycle
      if (wr_gnt_o && wr_req_i) begin
        for (int i = 0; i < 4; i++) begin
          if (wr_be_i[i]) begin
            mem[wr_addr_i[9:2]][8*i +: 8] <= wr_wdata_i[8*i +: 8];
          end
        end
      end else if (!wr_req_i) begin
        wr_armed <= 1'b0;
      end else if (!wr_armed) begin
        draw_delay(delay);
        wr_wait  <= delay;
        wr_armed <= 1'b1;
      end else if (wr_wait == '0) begin
        wr_gnt_o <= 1'b1;
        wr_armed <= 1'b0;
      end else begin
        wr_wait <= wr_wait - 1'b1;
      end
    end
  end

endmodule

// ==== tb_dma.sv ====
module tb_dma;
  timeunit 1ns;
  timeprecision 100ps;

  // Six tests of up to 16 transfers at about 30 cycles each plus margin
  localparam int unsigned TimeoutCycles = 4000;

  logic           clk, rst_n, slow;
  logic           reg_req, reg_we, reg_gnt, reg_rvalid, reg_err;
  dma_pkg::addr_t reg_addr;
  dma_pkg::data_t reg_wdata, reg_rdata;
  logic           rd_req, rd_gnt, rd_rvalid;
  dma_pkg::addr_t rd_addr;
  dma_pkg::data_t rd_rdata;
  logic           wr_req, wr_gnt, irq;
  dma_pkg::addr_t wr_addr;
  dma_pkg::be_t   wr_be;
  dma_pkg::data_t wr_wdata;

  // Value check strobe sampled by a_value
  logic           chk_en;
  dma_pkg::data_t chk_exp, chk_act;
  string          chk_name;
  logic           abort_sent, aborted, irq_quiet;
  int unsigned    cycles;

  dma i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .reg_req_i (reg_req), .reg_we_i (reg_we), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_gnt_o (reg_gnt), .reg_rvalid_o (reg_rvalid),
    .reg_rdata_o (reg_rdata), .reg_err_o (reg_err),
    .rd_req_o (rd_req), .rd_addr_o (rd_addr), .rd_gnt_i (rd_gnt),
    .rd_rvalid_i (rd_rvalid), .rd_rdata_i (rd_rdata),
    .wr_req_o (wr_req), .wr_addr_o (wr_addr), .wr_be_o (wr_be),
    .wr_wdata_o (wr_wdata), .wr_gnt_i (wr_gnt), .irq_o (irq)
  );

  tb_dma_mem i_mem (
    .clk_i (clk), .rst_ni (rst_n), .slow_i (slow),
    .rd_req_i (rd_req), .rd_addr_i (rd_addr), .rd_gnt_o (rd_gnt),
    .rd_rvalid_o (rd_rvalid), .rd_rdata_o (rd_rdata),
    .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_be_i (wr_be),
    .wr_wdata_i (wr_wdata), .wr_gnt_o (wr_gnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "Simulation stopped");
  endtask

  // --------------------------------------------------
  // Response checks
  // --------------------------------------------------
  a_value: assert property (@(posedge clk) chk_en |-> chk_act == chk_exp)
    else begin
      $display("** Error [%s] expected 0x%08h, actual 0x%08h", chk_name, chk_exp, chk_act);
      stop_with_failure();
    end
  a_gnt: assert property (@(posedge clk) disable iff (!rst_n) reg_gnt == reg_req)
    else begin
      $display("Register grant does not follow the request");
      stop_with_failure();
    end
  a_rvalid: assert property (@(posedge clk) disable iff (!rst_n) reg_rvalid == $past(reg_req))
    else begin
      $display("Register rvalid did not come exactly one cycle after the request");
      stop_with_failure();
    end
  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !rd_req && !wr_req && !irq && !reg_rvalid)
    else begin
      $display("Outputs were not idle after reset");
      stop_with_failure();
    end
  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_req && !rd_gnt && !abort_sent |=> rd_req && $stable(rd_addr))
    else begin
      $display("Read request dropped or changed before its grant");
      stop_with_failure();
    end
  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_gnt && !abort_sent |=>
      wr_req && $stable(wr_addr) && $stable(wr_wdata) && $stable(wr_be))
    else begin
      $display("Write request dropped or changed before its grant");
      stop_with_failure();
    end
  a_quiet_after_abort: assert property (@(posedge clk) aborted |-> !wr_req && !rd_req)
    else begin
      $display("A manager request appeared after the abort");
      stop_with_failure();
    end
  a_irq_disabled: assert property (@(posedge clk) irq_quiet |-> !irq)
    else begin
      $display("Interrupt rose although the interrupt enable was clear");
      stop_with_failure();
    end

  // Word pattern over the whole word address
  function automatic dma_pkg::data_t fill_word(logic [7:0] idx);
    return {idx ^ 8'h5A, idx + 8'h11, ~idx, idx};
  endfunction

  function automatic logic [7:0] mem_byte(dma_pkg::addr_t addr);
    dma_pkg::data_t word;
    word = fill_word(addr[9:2]);
    return word[{addr[1:0], 3'b000} +: 8];
  endfunction

  // Destination word after a byte copy of len bytes from src to dst
  function automatic dma_pkg::data_t byte_copy_word(dma_pkg::addr_t waddr, dma_pkg::addr_t src,
                                                    dma_pkg::addr_t dst, int unsigned len);
    dma_pkg::data_t word;
    dma_pkg::addr_t a;
    for (int lane = 0; lane < 4; lane++) begin
      a = waddr + lane;
      if (a >= dst && a < dst + len) begin
        word[8*lane +: 8] = mem_byte(src + (a - dst));
      end else begin
        word[8*lane +: 8] = mem_byte(a);
      end
    end
    return word;
  endfunction

  function automatic dma_pkg::data_t control_word(logic [7:0] src_off, logic [7:0] dst_off,
      logic [10:0] count, logic irq_en, logic inc_src, logic inc_dst, logic byte_size, logic act);
    return {src_off, dst_off, count, irq_en, inc_src, inc_dst, byte_size, act};
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
      i_mem.mem[i] = fill_word(8'(i));
    end
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  // Called 10 ns after an edge and returns in the response cycle
  task automatic bus_access(input logic we, input dma_pkg::addr_t addr,
                            input dma_pkg::data_t wdata,
                            output dma_pkg::data_t rdata, output logic err);
    reg_req   = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    wait_cycles(1);
    reg_req = 1'b0;
    reg_we  = 1'b0;
    while (!reg_rvalid) begin
      wait_cycles(1);
    end
    rdata = reg_rdata;
    err   = reg_err;
  endtask

  task automatic expect_value(input string name, input dma_pkg::data_t exp,
                              input dma_pkg::data_t act);
    chk_name = name;
    chk_exp  = exp;
    chk_act  = act;
    chk_en   = 1'b1;
    wait_cycles(1);
    chk_en = 1'b0;
  endtask

  task automatic write_ok(input string name, input dma_pkg::addr_t addr,
                          input dma_pkg::data_t data);
    dma_pkg::data_t rdata;
    logic           err;
    bus_access(1'b1, addr, data, rdata, err);
    expect_value(name, '0, {31'b0, err});
  endtask

  task automatic read_expect(input string name, input dma_pkg::addr_t addr,
                             input dma_pkg::data_t exp);
    dma_pkg::data_t rdata;
    logic           err;
    bus_access(1'b0, addr, '0, rdata, err);
    expect_value(name, exp, rdata);
    expect_value({name, " err"}, '0, {31'b0, err});
  endtask

  // Polls the status register until busy reads 0
  task automatic wait_until_idle(output dma_pkg::data_t status);
    logic err;
    do begin
      bus_access(1'b0, 32'h18, '0, status, err);
    end while (status[0]);
  endtask

  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    stop_with_failure();
  end

  initial begin
    dma_pkg::data_t rdata, status;
    logic           err;
    reg_req    = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    slow       = 1'b0;
    chk_en     = 1'b0;
    chk_exp    = '0;
    chk_act    = '0;
    chk_name   = "";
    abort_sent = 1'b0;
    aborted    = 1'b0;
    irq_quiet  = 1'b0;
    rst_n      = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    fill_memory();

    // Register readback
    write_ok("write src", 32'h00, 32'h1234_5678);
    write_ok("write dst", 32'h04, 32'h8765_4320);
    write_ok("write control", 32'h08, 32'hA5C3_1234);
    read_expect("readback src", 32'h00, 32'h1234_5678);
    read_expect("readback dst", 32'h04, 32'h8765_4320);
    read_expect("readback control", 32'h08, 32'hA5C3_1234);

    // Unmapped offset
    bus_access(1'b0, 32'h0C, '0, rdata, err);
    expect_value("read 0x0C err", 32'd1, {31'b0, err});
    bus_access(1'b1, 32'h0C, 32'hFFFF_FFFF, rdata, err);
    expect_value("write 0x0C err", 32'd1, {31'b0, err});

    // --------------------------------------------------
    // Word copy with a rejected write while busy
    // --------------------------------------------------
    write_ok("word src", 32'h00, 32'h040);
    write_ok("word dst", 32'h04, 32'h200);
    write_ok("word control", 32'h08, control_word(8'h10, 8'h08, 11'd8, 0, 1, 1, 0, 0));
    write_ok("word activate", 32'h14, '0);
    wait_cycles(2);
    bus_access(1'b1, 32'h00, 32'hDEAD_BEEF, rdata, err);
    expect_value("busy src write err", 32'd1, {31'b0, err});
    read_expect("busy src kept", 32'h00, 32'h040);
    wait_until_idle(status);
    expect_value("word status", {11'd9, 11'd9, 10'd0}, status);
    for (int k = 0; k < 8; k++) begin
      expect_value("word data", fill_word(8'(20 + k)), i_mem.mem[130 + k]);
    end

    // Byte copy from 0x103 to 0x305 that leaves the neighboring bytes intact
    fill_memory();
    write_ok("byte src", 32'h00, 32'h100);
    write_ok("byte dst", 32'h04, 32'h300);
    write_ok("byte control", 32'h08, control_word(8'h03, 8'h05, 11'd6, 0, 1, 1, 1, 1));
    wait_cycles(2);
    wait_until_idle(status);
    for (int a = 'h300; a < 'h310; a += 4) begin
      expect_value("byte data", byte_copy_word(a, 32'h103, 32'h305, 6), i_mem.mem[a >> 2]);
    end

    // Interrupt enabled and then disabled
    write_ok("irq control", 32'h08, control_word(8'h00, 8'h00, 11'd2, 1, 1, 1, 0, 1));
    while (!irq) begin
      wait_cycles(1);
    end
    // Level interrupt holds until the next access
    wait_cycles(1);
    expect_value("irq held", 32'd1, {31'b0, irq});
    read_expect("irq status", 32'h18, {11'd3, 11'd3, 10'd0});
    expect_value("irq cleared by read", '0, {31'b0, irq});
    irq_quiet = 1'b1;
    write_ok("no irq control", 32'h08, control_word(8'h00, 8'h00, 11'd2, 0, 1, 1, 0, 1));
    wait_cycles(2);
    wait_until_idle(status);
    wait_cycles(4);
    expect_value("irq stays low", '0, {31'b0, irq});
    irq_quiet = 1'b0;

    // Abort a long run with slow grants
    slow = 1'b1;
    write_ok("abort control", 32'h08, control_word(8'h00, 8'h00, 11'd16, 0, 1, 1, 0, 1));
    wait_cycles(30);
    bus_access(1'b0, 32'h18, '0, rdata, err);
    expect_value("busy before abort", 32'd1, {31'b0, rdata[0]});
    abort_sent = 1'b1;
    write_ok("abort write", 32'h10, '0);
    wait_cycles(1);
    aborted = 1'b1;
    bus_access(1'b0, 32'h18, '0, rdata, err);
    expect_value("busy after abort", '0, {31'b0, rdata[0]});
    wait_cycles(60);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
dma_pkg.sv
dma_cfg_if.sv
dma_fifo_if.sv
dma_regs.sv
dma_receiver.sv
dma_fifo.sv
dma_transmitter.sv
dma.sv
tb_dma_mem.sv
tb_dma.sv

// ==== Bender.yml ====
package:
  name: dma

sources:
  - files:
      - dma_pkg.sv
      - dma_cfg_if.sv
      - dma_fifo_if.sv
      - dma_regs.sv
      - dma_receiver.sv
      - dma_fifo.sv
      - dma_transmitter.sv
      - dma.sv
  - target: test
    files:
      - tb_dma_mem.sv
      - tb_dma.sv
